//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/memPkg.sv
      - hdl/memCtrl.sv
      - hdl/instFetch.sv
      - hdl/byteRam.sv
      - hdl/memSubsystem.sv
  - target: test
    files:
      - test/memSubsystemTb.sv

//--- build.f
hdl/memPkg.sv
hdl/memCtrl.sv
hdl/instFetch.sv
hdl/byteRam.sv
hdl/memSubsystem.sv
test/memSubsystemTb.sv

//--- hdl/byteRam.sv
module byteRam
    import memPkg::*;
#(
    parameter int ramAddrBits = 12
) (
    input  logic       clk,
    input  ramPort_t   ramPort,
    output logic [7:0] ramRdata
);
    logic [7:0]             mem [2**ramAddrBits];
    logic [ramAddrBits-1:0] index;

    // upper address bits are ignored
    assign index = ramPort.addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (ramPort.write) begin
            mem[index] <= ramPort.wdata;
        end
        // old data on a same-cycle write
        ramRdata <= mem[index];
    end

endmodule

//--- hdl/instFetch.sv
module instFetch
    import memPkg::*;
#(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchEnable,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    output logic        fetchEn,
    output logic [31:0] fetchAddr,
    input  fetchResp_t  fetchResp,
    output fetchOut_t   fetchOut
);
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic        launch;
    logic        discard;
    logic        outValid;
    logic [31:0] outPc;
    logic [31:0] outInst;

    // pc only tracks fetchAddr while nothing is discarded
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (fetchResp.done && !discard) begin
            pcNext = pc + 32'd4;
        end else begin
            pcNext = pc;
        end
    end

    assign launch = !fetchEn || fetchResp.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= resetPc;
            fetchEn  <= 1'b0;
            discard  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            pc       <= pcNext;
            outValid <= fetchResp.done && !discard && !redirect;
            if (launch) begin
                fetchEn <= fetchEnable;
            end
            if (fetchResp.done) begin
                discard <= 1'b0;
            end else if (redirect && fetchEn) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fetchAddr <= pcNext;
        end
        outPc   <= fetchAddr;
        outInst <= fetchResp.inst;
    end

    assign fetchOut = '{valid: outValid, pc: outPc, inst: outInst};

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

//--- hdl/memCtrl.sv
module memCtrl
    import memPkg::*;
#(
    parameter int ramAddrBits = 12
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ioBufferFull,
    input  logic        dataEn,
    input  dataReq_t    dataReq,
    output dataResp_t   dataResp,
    input  logic        fetchEn,
    input  logic [31:0] fetchAddr,
    output fetchResp_t  fetchResp,
    output ramPort_t    ramPort,
    input  logic [7:0]  ramRdata,
    output memOwner_t   owner
);
    logic [2:0]  stage;
    logic [2:0]  numBytes;
    logic [2:0]  capLane;
    logic [31:0] baseAddr;
    logic        isStore;
    logic        issuing;
    logic        lastStep;
    logic        anyDone;
    logic        rdPending;
    logic [31:0] assembly;
    logic [31:0] assembled;
    logic        dataDone;
    logic [31:0] dataRdata;
    logic        fetchDone;
    logic [31:0] fetchInst;

    // request fields are held steady by the requester until done
    always_comb begin
        if (owner == ownerFetch) begin
            baseAddr = fetchAddr;
            numBytes = 3'd4;
            isStore  = 1'b0;
        end else begin
            baseAddr = dataReq.addr;
            numBytes = lenBytes(dataReq.len);
            isStore  = dataReq.isStore;
        end
    end

    assign issuing = (owner != ownerIdle) && (stage < numBytes);
    // loads need one more cycle for the last byte to come back
    assign lastStep = isStore ? (stage == numBytes - 3'd1) : (stage == numBytes);
    assign anyDone = dataDone || fetchDone;

    assign ramPort.addr  = baseAddr + 32'(stage);
    assign ramPort.wdata = dataReq.wdata[{stage[1:0], 3'b000} +: 8];
    assign ramPort.write = isStore && issuing && !ioBufferFull;

    // byte read at the previous edge belongs to lane stage-1
    assign capLane = stage - 3'd1;

    always_comb begin
        assembled = assembly;
        if (rdPending) begin
            assembled[{capLane[1:0], 3'b000} +: 8] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner     <= ownerIdle;
            stage     <= '0;
            rdPending <= 1'b0;
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
            rdPending <= 1'b0;
            if (!ioBufferFull) begin
                if (owner == ownerIdle) begin
                    stage <= '0;
                    // data wins and a stale enable never restarts
                    if (!anyDone && dataEn) begin
                        owner <= ownerData;
                    end else if (!anyDone && fetchEn) begin
                        owner <= ownerFetch;
                    end
                end else if (lastStep) begin
                    owner     <= ownerIdle;
                    dataDone  <= (owner == ownerData);
                    fetchDone <= (owner == ownerFetch);
                end else begin
                    stage     <= stage + 3'd1;
                    rdPending <= !isStore;
                end
            end
        end
    end

    // a stall edge still captures the pending byte before the RAM re-reads
    always_ff @(posedge clk) begin
        if (owner == ownerIdle) begin
            assembly <= '0;
        end else begin
            assembly <= assembled;
        end
        if (!ioBufferFull && lastStep && owner == ownerData && !isStore) begin
            dataRdata <= assembled;
        end
        if (!ioBufferFull && lastStep && owner == ownerFetch) begin
            fetchInst <= assembled;
        end
    end

    assign dataResp  = '{done: dataDone, rdata: dataRdata};
    assign fetchResp = '{done: fetchDone, inst: fetchInst};

    doneIsPulse: assert property (@(posedge clk) disable iff (rst)
        anyDone |=> !anyDone);

    writeOnlyForData: assert property (@(posedge clk) disable iff (rst)
        ramPort.write |-> owner == ownerData);

    addrInRange: assert property (@(posedge clk) disable iff (rst)
        issuing |-> (ramPort.addr >> ramAddrBits) == '0);

endmodule

//--- hdl/memPkg.sv
package memPkg;

    // access size as issued by the data path
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen_t;

    typedef enum logic [1:0] {
        ownerIdle  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } memOwner_t;

    typedef struct packed {
        logic        isStore;
        accessLen_t  len;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dataReq_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } dataResp_t;

    typedef struct packed {
        logic        done;
        logic [31:0] inst;
    } fetchResp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetchOut_t;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [7:0]  wdata;
    } ramPort_t;

    // byte count of an access
    function automatic logic [2:0] lenBytes(accessLen_t len);
        case (len)
            lenByte: return 3'd1;
            lenHalf: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

//--- hdl/memSubsystem.sv
module memSubsystem
    import memPkg::*;
#(
    parameter int          ramAddrBits = 12,
    parameter logic [31:0] resetPc     = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ioBufferFull,
    input  logic        fetchEnable,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    input  logic        dataEn,
    input  dataReq_t    dataReq,
    output dataResp_t   dataResp,
    output fetchOut_t   fetchOut,
    output memOwner_t   owner
);
    logic        fetchEn;
    logic [31:0] fetchAddr;
    fetchResp_t  fetchResp;
    ramPort_t    ramPort;
    logic [7:0]  ramRdata;

    instFetch #(
        .resetPc(resetPc)
    ) fetchUnit (
        .clk(clk),
        .rst(rst),
        .fetchEnable(fetchEnable),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .fetchResp(fetchResp),
        .fetchOut(fetchOut)
    );

    memCtrl #(
        .ramAddrBits(ramAddrBits)
    ) ctrl (
        .clk(clk),
        .rst(rst),
        .ioBufferFull(ioBufferFull),
        .dataEn(dataEn),
        .dataReq(dataReq),
        .dataResp(dataResp),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .fetchResp(fetchResp),
        .ramPort(ramPort),
        .ramRdata(ramRdata),
        .owner(owner)
    );

    byteRam #(
        .ramAddrBits(ramAddrBits)
    ) ram (
        .clk(clk),
        .ramPort(ramPort),
        .ramRdata(ramRdata)
    );

endmodule

//--- test/memSubsystemTb.sv
module memSubsystemTb
    import memPkg::*;
();
    localparam int timeoutCycles = 300;

    logic        clk;
    logic        rst;
    logic        ioBufferFull;
    logic        fetchEnable;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        dataEn;
    dataReq_t    dataReq;
    dataResp_t   dataResp;
    fetchOut_t   fetchOut;
    memOwner_t   owner;

    logic        stallOn;
    logic [7:0]  lfsr;
    logic        fetchRunning;
    memOwner_t   prevOwner;
    logic [31:0] fetchWords[$];

    memSubsystem #(
        .ramAddrBits(12),
        .resetPc(32'h0)
    ) memSubsystem_inst (
        .clk(clk),
        .rst(rst),
        .ioBufferFull(ioBufferFull),
        .fetchEnable(fetchEnable),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .dataEn(dataEn),
        .dataReq(dataReq),
        .dataResp(dataResp),
        .fetchOut(fetchOut),
        .owner(owner)
    );

    always #20 clk = ~clk;

    task automatic reportError(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hb8;
        end
        return state >> 1;
    endfunction

    task automatic checkData(string name, dataResp_t expected, dataResp_t actual);
        if (actual.done !== expected.done
                || (expected.done && actual.rdata !== expected.rdata)) begin
            reportError($sformatf("Fail at time %0t: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic checkFetch(string name, fetchOut_t expected, fetchOut_t actual);
        if (actual.valid !== expected.valid
                || (expected.valid && (actual.pc !== expected.pc
                || actual.inst !== expected.inst))) begin
            reportError($sformatf("Fail at time %0t: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic checkOwner(string name, memOwner_t expected, memOwner_t actual);
        if (actual !== expected) begin
            reportError($sformatf("Fail at time %0t: %s expected %0d, got %0d",
                $time, name, expected, actual));
        end
    endtask

    // two bits per cycle, stall when both are set
    always @(posedge clk) begin
        logic bitA;
        logic bitB;
        if (stallOn) begin
            bitA = lfsr[0];
            lfsr = lfsrNext(lfsr);
            bitB = lfsr[0];
            lfsr = lfsrNext(lfsr);
            ioBufferFull <= bitA & bitB;
        end else begin
            ioBufferFull <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            prevOwner = ownerIdle;
        end else begin
            if (owner != prevOwner && prevOwner != ownerIdle) begin
                if (owner != ownerIdle) begin
                    reportError("owner switched requesters without going idle");
                end else if (prevOwner == ownerData && !dataResp.done) begin
                    reportError("owner left the data side without a done pulse");
                end
            end
            prevOwner = owner;
        end
    end

    // the request goes out one edge before the controller can start it
    task automatic dataAccess(logic isStore, int len, logic [31:0] addr, logic [31:0] value);
        int        cycles;
        int        stalls;
        int        expCycles;
        logic      seen;
        dataReq_t  req;
        dataResp_t expected;
        req.isStore = isStore;
        case (len)
            1: req.len = lenByte;
            2: req.len = lenHalf;
            default: req.len = lenWord;
        endcase
        req.addr  = addr;
        req.wdata = value;
        cycles = 0;
        stalls = 0;
        seen   = 1'b0;
        @(posedge clk);
        dataEn  <= 1'b1;
        dataReq <= req;
        while (!seen && cycles < timeoutCycles) begin
            @(negedge clk);
            if (dataResp.done) begin
                seen = 1'b1;
            end else begin
                cycles++;
                // level seen by the controller at the coming edge
                if (ioBufferFull) begin
                    stalls++;
                end
            end
        end
        if (!seen) begin
            reportError("timed out waiting for the data done pulse");
        end
        if (!isStore) begin
            expected.done  = 1'b1;
            expected.rdata = value;
            checkData("dataResp", expected, dataResp);
        end
        if (!fetchRunning) begin
            expCycles = (isStore ? len + 1 : len + 2) + stalls;
            if (cycles != expCycles) begin
                reportError($sformatf("Fail at time %0t: data latency expected %0d, got %0d",
                    $time, expCycles, cycles));
            end
        end
        @(posedge clk);
        dataEn <= 1'b0;
    endtask

    task automatic fetchStream(logic [31:0] target, int count);
        int        k;
        int        waited;
        fetchOut_t expected;
        @(posedge clk);
        redirect    <= 1'b1;
        redirectPc  <= target;
        fetchEnable <= 1'b1;
        fetchRunning = 1'b1;
        @(posedge clk);
        redirect <= 1'b0;
        k = 0;
        waited = 0;
        // anything older than the redirect would show a stale pc here
        while (k < count && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
            if (fetchOut.valid) begin
                expected.valid = 1'b1;
                expected.pc    = target + 32'(4 * k);
                expected.inst  = fetchWords[k];
                checkFetch("fetchOut", expected, fetchOut);
                k++;
                waited = 0;
            end
        end
        if (k < count) begin
            reportError("timed out waiting for a fetched instruction");
        end
    endtask

    task automatic drainFetch();
        int   quiet;
        int   waited;
        logic lastStall;
        @(posedge clk);
        fetchEnable <= 1'b0;
        quiet     = 0;
        waited    = 0;
        lastStall = 1'b1;
        // only unstalled idle edges prove the fetch side has stopped
        while (quiet < 4 && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
            if (owner != ownerIdle) begin
                quiet = 0;
            end else if (!lastStall) begin
                quiet++;
            end
            lastStall = ioBufferFull;
        end
        if (quiet < 4) begin
            reportError("fetch unit did not go idle after fetchEnable dropped");
        end
        fetchRunning = 1'b0;
    endtask

    initial begin
        string       tok;
        string       rest;
        int          fd;
        int          code;
        int          len;
        int          count;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] word;
        clk          = 1'b0;
        rst          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEnable  = 1'b0;
        redirect     = 1'b0;
        redirectPc   = '0;
        dataEn       = 1'b0;
        dataReq      = '0;
        stallOn      = 1'b0;
        lfsr         = 8'd68;
        fetchRunning = 1'b0;
        prevOwner    = ownerIdle;
        repeat (15) begin
            @(negedge clk);
            checkOwner("owner", ownerIdle, owner);
            checkData("dataResp", '0, dataResp);
            checkFetch("fetchOut", '0, fetchOut);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkOwner("owner", ownerIdle, owner);
        checkData("dataResp", '0, dataResp);
        checkFetch("fetchOut", '0, fetchOut);

        fd = $fopen("test/memTests.txt", "r");
        if (fd == 0) begin
            reportError("could not open test/memTests.txt");
        end
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "S" || tok == "L") begin
                code = $fscanf(fd, "%d %h %h", len, addr, value);
                if (code != 3) begin
                    reportError("malformed data line in the test file");
                end
                dataAccess(tok == "S", len, addr, value);
            end else if (tok == "F") begin
                code = $fscanf(fd, "%h %d", addr, count);
                fetchWords.delete();
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", word);
                    fetchWords.push_back(word);
                end
                if (count == 0) begin
                    drainFetch();
                end else begin
                    fetchStream(addr, count);
                end
            end else if (tok == "P") begin
                code = $fscanf(fd, "%d", len);
                @(posedge clk);
                stallOn <= (len != 0);
            end else begin
                reportError($sformatf("unknown opcode %s in the test file", tok));
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);

        if (fetchRunning) begin
            drainFetch();
        end
        checkOwner("owner", ownerIdle, owner);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- test/memTests.txt
# S len addr wdata | L len addr expected | P 1 stalls on, 0 off (len in bytes, rest hex)
# F pc count then count expected words, count 0 stops the fetch unit
S 4 00000100 44332211
L 1 00000102 00000033
L 2 00000100 00002211
L 2 00000102 00004433
L 4 00000100 44332211
L 1 00000103 00000044
S 1 00000104 0000005a
S 1 00000105 000000a5
S 2 00000106 0000c3b7
L 4 00000104 c3b7a55a
S 4 00000108 12345678
S 2 00000108 ffffbeef
S 1 0000010a 0000009c
L 4 00000108 129cbeef
S 4 00000200 00000013
S 4 00000204 00100093
S 4 00000208 00200113
S 4 0000020c 00300193
S 4 00000300 0aa00513
S 4 00000304 0bb00593
F 00000200 4 00000013 00100093 00200113 00300193
L 2 00000106 0000c3b7
S 4 00000110 deadbeef
L 2 00000112 0000dead
F 00000300 2 0aa00513 0bb00593
L 1 00000111 000000be
P 1
S 2 00000114 00007788
L 2 00000114 00007788
F 00000204 3 00100093 00200113 00300193
F 00000000 0
L 4 00000110 deadbeef
S 1 00000118 00000042
L 1 00000118 00000042
L 4 00000108 129cbeef
P 0
L 2 0000010a 0000129c
